// File: rtl/sine_synth_pkg.sv
// Sine synthesizer shared definitions
`default_nettype none

package sine_synth_pkg;

    // Phase word, a full turn is 2**PHASE_W units
    localparam int PHASE_W = 16;

    // Angle inside one quadrant
    localparam int ANGLE_W = PHASE_W - 2;

    // Signed sample width and the rotator's working width with two guard bits
    localparam int DATA_W = 12;
    localparam int XY_W   = DATA_W + 2;

    // Residual angle register of the rotator
    localparam int Z_W = PHASE_W;

    // One micro-rotation per clock
    localparam int ITERATIONS = 12;
    localparam int ITER_W     = $clog2(ITERATIONS);

    // CORDIC gain compensation scaled to full output range
    localparam int GAIN_INIT = 1243;

    // Output clamp, symmetric around zero
    localparam int SAT_MAX = 2 ** (DATA_W - 1) - 1;

    // atan(2**-i) in phase units
    localparam logic [Z_W-1:0] ATAN_TABLE [ITERATIONS] = '{
        16'd8192, 16'd4836, 16'd2555, 16'd1297,
        16'd651,  16'd326,  16'd163,  16'd81,
        16'd41,   16'd20,   16'd10,   16'd5
    };

    typedef logic [PHASE_W-1:0]        phase_t;
    typedef logic signed [DATA_W-1:0]  data_t;
    typedef logic signed [XY_W-1:0]    xy_t;

    // Top two phase bits
    typedef enum logic [1:0] {
        Q0 = 2'd0,
        Q1 = 2'd1,
        Q2 = 2'd2,
        Q3 = 2'd3
    } quadrant_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ROTATE = 2'd1,
        DONE   = 2'd2
    } cordic_state_e;

    typedef struct packed {
        phase_t                phase;
        quadrant_e             quadrant;
        logic [ANGLE_W-1:0]    angle;
    } fold_t;

    typedef struct packed {
        phase_t    phase;
        data_t     sine;
        data_t     cosine;
    } sample_t;

endpackage

`default_nettype wire

// File: rtl/ks_adder.sv
// Kogge-Stone prefix adder
`default_nettype none

module ks_adder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             carry_in,
    output logic [WIDTH-1:0] sum
);

    localparam int LEVELS = $clog2(WIDTH);

    logic [WIDTH-1:0] prop;
    logic [WIDTH-1:0] gen;

    // Group generate and propagate after each prefix level
    wire [WIDTH-1:0] gen_l  [LEVELS+1];
    wire [WIDTH-1:0] prop_l [LEVELS+1];

    assign prop = a ^ b;
    assign gen  = a & b;

    // Carry input folds into the generate of bit 0
    assign gen_l[0]  = gen | {{(WIDTH-1){1'b0}}, prop[0] & carry_in};
    assign prop_l[0] = prop;

    genvar lvl;
    genvar k;
    generate
        for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
            localparam int DIST = 1 << lvl;
            for (k = 0; k < WIDTH; k++) begin : g_bit
                if (k >= DIST) begin : g_merge
                    assign gen_l[lvl+1][k]  = gen_l[lvl][k] |
                                              (prop_l[lvl][k] & gen_l[lvl][k-DIST]);
                    assign prop_l[lvl+1][k] = prop_l[lvl][k] & prop_l[lvl][k-DIST];
                end else begin : g_pass
                    // Group already reaches bit 0
                    assign gen_l[lvl+1][k]  = gen_l[lvl][k];
                    assign prop_l[lvl+1][k] = prop_l[lvl][k];
                end
            end
        end
    endgenerate

    // Carry into bit k is the group generate of bits k-1 down to 0
    assign sum = prop ^ {gen_l[LEVELS][WIDTH-2:0], carry_in};

endmodule

`default_nettype wire

// File: rtl/phase_accumulator.sv
// Phase accumulator
`default_nettype none

module phase_accumulator (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    run,
    input  sine_synth_pkg::phase_t  step,
    output logic                    phase_valid,
    input  logic                    phase_ready,
    output sine_synth_pkg::phase_t  phase
);

    logic accept;

    // A phase is on offer for as long as the oscillator runs
    assign phase_valid = run;
    assign accept      = phase_valid & phase_ready;

    // Advance only on acceptance so stalls leave no gaps in the sequence
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            phase <= '0;
        end else if (accept) begin
            phase <= phase + step;  // wraps modulo a full turn
        end
    end

endmodule

`default_nettype wire

// File: rtl/quadrant_fold.sv
// Quadrant fold stage
`default_nettype none

module quadrant_fold (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    phase_valid,
    output logic                    phase_ready,
    input  sine_synth_pkg::phase_t  phase,
    output logic                    fold_valid,
    input  logic                    fold_ready,
    output sine_synth_pkg::fold_t   fold
);

    logic load;

    // Room when empty or when the held item drains this cycle
    assign phase_ready = ~fold_valid | fold_ready;
    assign load        = phase_valid & phase_ready;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            fold_valid <= 1'b0;
        end else if (phase_ready) begin
            fold_valid <= phase_valid;
        end
    end

    // Top two bits pick the quadrant, the rest is the angle inside it
    always_ff @(posedge clock) begin
        if (load) begin
            fold.phase    <= phase;
            fold.quadrant <= sine_synth_pkg::quadrant_e'(
                                 phase[sine_synth_pkg::PHASE_W-1 -: 2]);
            fold.angle    <= phase[sine_synth_pkg::ANGLE_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/cordic_rotator.sv
// Iterative CORDIC rotator
`default_nettype none

module cordic_rotator (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     fold_valid,
    output logic                     fold_ready,
    input  sine_synth_pkg::fold_t    fold,
    output logic                     out_valid,
    input  logic                     out_ready,
    output sine_synth_pkg::sample_t  out_sample
);

    sine_synth_pkg::cordic_state_e state;
    logic [sine_synth_pkg::ITER_W-1:0] iter;

    // Working registers
    sine_synth_pkg::xy_t        x;
    sine_synth_pkg::xy_t        y;
    logic [sine_synth_pkg::Z_W-1:0] z;
    sine_synth_pkg::quadrant_e  quad;
    sine_synth_pkg::phase_t     phase_q;

    sine_synth_pkg::xy_t        x_shift;
    sine_synth_pkg::xy_t        y_shift;
    logic [sine_synth_pkg::Z_W-1:0] atan_step;
    logic                       dir_pos;

    // Adder operands and results
    sine_synth_pkg::xy_t        x_add_b;
    sine_synth_pkg::xy_t        y_add_b;
    sine_synth_pkg::xy_t        x_add_a;
    sine_synth_pkg::xy_t        y_add_a;
    logic                       x_add_cin;
    logic                       y_add_cin;
    sine_synth_pkg::xy_t        x_sum;
    sine_synth_pkg::xy_t        y_sum;
    logic [sine_synth_pkg::Z_W-1:0] z_sum;

    sine_synth_pkg::xy_t        sin_raw;
    sine_synth_pkg::xy_t        cos_raw;
    logic                       forming;

    function automatic sine_synth_pkg::data_t saturate(input sine_synth_pkg::xy_t value);
        if (value > sine_synth_pkg::SAT_MAX) begin
            return sine_synth_pkg::data_t'(sine_synth_pkg::SAT_MAX);
        end else if (value < -sine_synth_pkg::SAT_MAX) begin
            return sine_synth_pkg::data_t'(-sine_synth_pkg::SAT_MAX);
        end
        return sine_synth_pkg::data_t'(value);
    endfunction

    assign fold_ready = (state == sine_synth_pkg::IDLE);
    assign forming    = (state == sine_synth_pkg::DONE) & ~out_valid;

    assign x_shift   = x >>> iter;
    assign y_shift   = y >>> iter;
    assign atan_step = sine_synth_pkg::ATAN_TABLE[iter];
    assign dir_pos   = ~z[sine_synth_pkg::Z_W-1];

    // Outside ROTATE the x and y adders negate for quadrant restoration
    always_comb begin
        if (state == sine_synth_pkg::ROTATE) begin
            x_add_a   = x;
            x_add_b   = dir_pos ? ~y_shift : y_shift;
            x_add_cin = dir_pos;
            y_add_a   = y;
            y_add_b   = dir_pos ? x_shift : ~x_shift;
            y_add_cin = ~dir_pos;
        end else begin
            x_add_a   = '0;
            x_add_b   = ~x;
            x_add_cin = 1'b1;
            y_add_a   = '0;
            y_add_b   = ~y;
            y_add_cin = 1'b1;
        end
    end

    ks_adder #(.WIDTH(sine_synth_pkg::XY_W)) u_x_adder (
        .a        (x_add_a),
        .b        (x_add_b),
        .carry_in (x_add_cin),
        .sum      (x_sum)
    );

    ks_adder #(.WIDTH(sine_synth_pkg::XY_W)) u_y_adder (
        .a        (y_add_a),
        .b        (y_add_b),
        .carry_in (y_add_cin),
        .sum      (y_sum)
    );

    // z steers toward zero
    ks_adder #(.WIDTH(sine_synth_pkg::Z_W)) u_z_adder (
        .a        (z),
        .b        (dir_pos ? ~atan_step : atan_step),
        .carry_in (dir_pos),
        .sum      (z_sum)
    );

    // Map first-quadrant results back, x_sum and y_sum hold -x and -y here
    always_comb begin
        case (quad)
            sine_synth_pkg::Q0: begin sin_raw = y;     cos_raw = x;     end
            sine_synth_pkg::Q1: begin sin_raw = x;     cos_raw = y_sum; end
            sine_synth_pkg::Q2: begin sin_raw = y_sum; cos_raw = x_sum; end
            default:            begin sin_raw = x_sum; cos_raw = y;     end
        endcase
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            state     <= sine_synth_pkg::IDLE;
            iter      <= '0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                sine_synth_pkg::IDLE: begin
                    iter <= '0;
                    if (fold_valid) begin
                        state <= sine_synth_pkg::ROTATE;
                    end
                end
                sine_synth_pkg::ROTATE: begin
                    if (iter == sine_synth_pkg::ITER_W'(sine_synth_pkg::ITERATIONS - 1)) begin
                        state <= sine_synth_pkg::DONE;
                    end else begin
                        iter <= iter + 1'b1;
                    end
                end
                sine_synth_pkg::DONE: begin
                    // First DONE cycle forms the result, then hold until taken
                    if (!out_valid) begin
                        out_valid <= 1'b1;
                    end else if (out_ready) begin
                        out_valid <= 1'b0;
                        state     <= sine_synth_pkg::IDLE;
                    end
                end
                default: state <= sine_synth_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fold_valid && fold_ready) begin
            x       <= sine_synth_pkg::xy_t'(sine_synth_pkg::GAIN_INIT);
            y       <= '0;
            z       <= sine_synth_pkg::Z_W'(fold.angle);
            quad    <= fold.quadrant;
            phase_q <= fold.phase;
        end else if (state == sine_synth_pkg::ROTATE) begin
            x <= x_sum;
            y <= y_sum;
            z <= z_sum;
        end
        if (forming) begin
            out_sample.phase  <= phase_q;
            out_sample.sine   <= saturate(sin_raw);
            out_sample.cosine <= saturate(cos_raw);
        end
    end

endmodule

`default_nettype wire

// File: rtl/sine_synth_top.sv
// Sine and cosine synthesizer top
`default_nettype none

module sine_synth_top (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     run,
    input  sine_synth_pkg::phase_t   step,
    output logic                     out_valid,
    input  logic                     out_ready,
    output sine_synth_pkg::sample_t  out_sample
);

    // Accumulator to fold stage
    logic                    phase_valid;
    logic                    phase_ready;
    sine_synth_pkg::phase_t  phase;

    // Fold stage to rotator
    logic                    fold_valid;
    logic                    fold_ready;
    sine_synth_pkg::fold_t   fold;

    phase_accumulator u_phase_accumulator (
        .clock       (clock),
        .resetn      (resetn),
        .run         (run),
        .step        (step),
        .phase_valid (phase_valid),
        .phase_ready (phase_ready),
        .phase       (phase)
    );

    quadrant_fold u_quadrant_fold (
        .clock       (clock),
        .resetn      (resetn),
        .phase_valid (phase_valid),
        .phase_ready (phase_ready),
        .phase       (phase),
        .fold_valid  (fold_valid),
        .fold_ready  (fold_ready),
        .fold        (fold)
    );

    cordic_rotator u_cordic_rotator (
        .clock       (clock),
        .resetn      (resetn),
        .fold_valid  (fold_valid),
        .fold_ready  (fold_ready),
        .fold        (fold),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_sample  (out_sample)
    );

endmodule

`default_nettype wire

// File: verif/sine_synth_tb.sv
// Sine synthesizer testbench
`default_nettype none

module sine_synth_tb;

    localparam int  ITERATIONS     = sine_synth_pkg::ITERATIONS;
    localparam int  TIMEOUT_CYCLES = 400 * (ITERATIONS + 3) * 4;
    localparam int  DRAIN_CYCLES   = 2 * (ITERATIONS + 2);
    localparam real PI             = 3.14159265358979;

    logic                     clock;
    logic                     resetn;
    logic                     run;
    sine_synth_pkg::phase_t   step;
    logic                     out_valid;
    logic                     out_ready;
    sine_synth_pkg::sample_t  out_sample;

    integer                   seed = 38;
    logic                     ready_random;
    int                       received = 0;

    // Model state owned by the output monitor
    sine_synth_pkg::sample_t  expected_q [$];
    sine_synth_pkg::phase_t   model_phase = '0;
    logic                     holding = 1'b0;
    sine_synth_pkg::sample_t  held_sample;

    sine_synth_top u_sine_synth_top (
        .clock      (clock),
        .resetn     (resetn),
        .run        (run),
        .step       (step),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_sample (out_sample)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic compare_values(input logic [63:0] actual, input logic [63:0] expected,
                                  input string what);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic signed [11:0] clamp_sample(input logic signed [13:0] v);
        if (v > 14'sd2047) begin
            return 12'sd2047;
        end
        if (v < -14'sd2047) begin
            return -12'sd2047;
        end
        return v[11:0];
    endfunction

    // Bit-accurate rotation of the folded angle followed by quadrant mapping
    function automatic sine_synth_pkg::sample_t model_sample(input sine_synth_pkg::phase_t p);
        logic signed [13:0]       x;
        logic signed [13:0]       y;
        logic signed [13:0]       xs;
        logic signed [13:0]       ys;
        logic signed [15:0]       z;
        logic signed [13:0]       sin_v;
        logic signed [13:0]       cos_v;
        sine_synth_pkg::sample_t  s;
        x = 14'(sine_synth_pkg::GAIN_INIT);
        y = '0;
        z = {2'b00, p[13:0]};
        for (int i = 0; i < ITERATIONS; i++) begin
            xs = x >>> i;
            ys = y >>> i;
            if (!z[15]) begin
                x = x - ys;
                y = y + xs;
                z = z - sine_synth_pkg::ATAN_TABLE[i];
            end else begin
                x = x + ys;
                y = y - xs;
                z = z + sine_synth_pkg::ATAN_TABLE[i];
            end
        end
        case (p[15:14])
            2'd0: begin
                sin_v = y;
                cos_v = x;
            end
            2'd1: begin
                sin_v = x;
                cos_v = -y;
            end
            2'd2: begin
                sin_v = -y;
                cos_v = -x;
            end
            default: begin
                sin_v = -x;
                cos_v = y;
            end
        endcase
        s.phase  = p;
        s.sine   = clamp_sample(sin_v);
        s.cosine = clamp_sample(cos_v);
        return s;
    endfunction

    // Next expected sample follows the running sum of step from 0
    task automatic push_expected();
        expected_q.push_back(model_sample(model_phase));
        model_phase = model_phase + step;
    endtask

    task automatic check_against_ideal(input sine_synth_pkg::sample_t s);
        real angle;
        real sin_err;
        real cos_err;
        angle   = 2.0 * PI * $itor(s.phase) / 65536.0;
        sin_err = $itor($signed(s.sine)) - 2047.0 * $sin(angle);
        cos_err = $itor($signed(s.cosine)) - 2047.0 * $cos(angle);
        compare_values(sin_err <= 8.0 && sin_err >= -8.0, 1'b1, "sine far from ideal");
        compare_values(cos_err <= 8.0 && cos_err >= -8.0, 1'b1, "cosine far from ideal");
    endtask

    // Random back-pressure with out_ready high about 70 percent of the time
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clock);
            out_ready <= ready_random ? (({$random(seed)} % 100) < 70) : 1'b1;
        end
    end

    // Output monitor sees the values in effect at this edge
    always @(posedge clock) begin
        sine_synth_pkg::sample_t expected;
        if (resetn) begin
            if (holding) begin
                compare_values(out_valid, 1'b1, "out_valid dropped before acceptance");
                compare_values(out_sample, held_sample, "out_sample changed while stalled");
            end
            holding     = out_valid && !out_ready;
            held_sample = out_sample;
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    push_expected();
                end
                expected = expected_q.pop_front();
                compare_values(out_sample.phase, expected.phase, "sample phase");
                compare_values(out_sample.sine, expected.sine, "sine against model");
                compare_values(out_sample.cosine, expected.cosine, "cosine against model");
                check_against_ideal(out_sample);
                received <= received + 1;
            end
        end
    end

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            compare_values(out_valid, 1'b0, "out_valid high with an empty pipeline");
        end
    endtask

    // Pipeline is empty once out_valid stays low long enough with run low
    task automatic drain_pipeline();
        int quiet;
        quiet = 0;
        while (quiet < DRAIN_CYCLES) begin
            @(posedge clock);
            if (out_valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic run_burst(input sine_synth_pkg::phase_t new_step, input int count,
                             input bit hold_ready);
        int target;
        int latency;
        @(posedge clock);
        step         <= new_step;
        ready_random <= !hold_ready;
        @(posedge clock);
        run <= 1'b1;
        if (hold_ready) begin
            // Accumulator, fold stage, rotation and result forming
            latency = 0;
            @(posedge clock);
            while (!out_valid) begin
                latency++;
                @(posedge clock);
            end
            compare_values(latency, ITERATIONS + 3, "cycles from run rise to out_valid");
        end
        target = received + count;
        while (received < target) begin
            @(posedge clock);
        end
        run <= 1'b0;
        drain_pipeline();
        check_idle(4);
    endtask

    initial begin
        sine_synth_pkg::phase_t burst_step;
        resetn       = 1'b0;
        run          = 1'b0;
        step         = '0;
        ready_random = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clock);
            if (i > 0) begin
                compare_values(out_valid, 1'b0, "out_valid high during reset");
            end
        end
        resetn <= 1'b1;
        check_idle(4);

        // Quarter-turn steps visit every quadrant
        run_burst(16'd16384, 24, 1'b1);
        run_burst(16'd0, 16, 1'b0);
        run_burst(16'd16384, 20, 1'b0);
        for (int b = 0; b < 8; b++) begin
            burst_step = 16'($random(seed));
            run_burst(burst_step, 30, b == 4);
        end

        $display("All checks passed");
        $finish;
    end

    initial begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

// File: sine_synth_top.f
rtl/sine_synth_pkg.sv
rtl/ks_adder.sv
rtl/phase_accumulator.sv
rtl/quadrant_fold.sv
rtl/cordic_rotator.sv
rtl/sine_synth_top.sv
verif/sine_synth_tb.sv

// File: Bender.yml
package:
  name: sine_synth

sources:
  # Design sources in compile order
  - files:
      - rtl/sine_synth_pkg.sv
      - rtl/ks_adder.sv
      - rtl/phase_accumulator.sv
      - rtl/quadrant_fold.sv
      - rtl/cordic_rotator.sv
      - rtl/sine_synth_top.sv

  # Testbench
  - target: test
    files:
      - verif/sine_synth_tb.sv
